//--- rv_alu.f
+incdir+design
design/alu_pkg.sv
design/alu_multiplier.sv
design/alu_divider.sv
design/alu.sv
dv/tb_clkgen.sv
dv/alu_tb.sv

//--- Makefile
# Verilator build and run of the alu testbench, invoked from the project root

TOP = alu_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f rv_alu.f
	./obj_dir/V$(TOP) | awk '{ print } /^sim passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- dv/alu_trace.txt
// alu trace, one operation per line, all fields hex
// op a b result remainder zero negative borrow, a line with op ffffffff ends the trace
00 f0f0f0f0 ff00ff00 f000f000 00000000 0 1 0
01 f0f0f0f0 0f0f0f0f ffffffff 00000000 0 1 0
02 7fffffff 00000001 80000000 00000000 0 1 0
02 ffffffff 00000001 00000000 00000000 1 0 0
03 12345678 12345678 00000000 00000000 1 0 0
04 00000005 00000007 fffffffe 00000000 0 1 0
05 0000ffff 12345678 ffff0000 00000000 0 1 0
06 00000001 0000001f 80000000 00000000 0 1 0
06 00000003 00000024 00000030 00000000 0 0 0
07 80000000 0000001f 00000001 00000000 0 0 0
07 ffffffff 00000020 ffffffff 00000000 0 1 0
08 80000000 00000004 f8000000 00000000 0 1 0
08 f0000000 00000021 f8000000 00000000 0 1 0
09 ffffffff 00000001 00000001 00000000 0 0 0
0a ffffffff 00000001 00000000 00000000 1 0 0
09 00000001 80000000 00000000 00000000 1 0 0
0a 00000001 80000000 00000001 00000000 0 0 0
14 ffffffff 00000001 00000001 00000000 0 0 0
15 ffffffff 00000001 00000001 00000000 0 0 0
16 ffffffff 00000001 ffffffff 00000000 0 1 0
17 ffffffff 00000001 ffffffff 00000000 0 1 0
17 00000005 00000005 00000005 00000000 0 0 0
0b 00000007 fffffffd ffffffeb 00000000 0 1 0
0c 80000000 80000000 40000000 00000000 0 0 0
0b 80000000 80000000 00000000 00000000 1 0 0
0c 80000000 ffffffff 00000000 00000000 1 0 0
0d 80000000 ffffffff 80000000 00000000 0 1 0
0e ffffffff ffffffff fffffffe 00000000 0 1 0
0b 80000000 ffffffff 80000000 00000000 0 1 0
0e 80000000 80000000 40000000 00000000 0 0 0
0f 00000014 fffffffa fffffffd 00000002 0 1 0
10 ffffffff 00000010 0fffffff 0000000f 0 0 0
11 ffffffec 00000006 fffffffe fffffffe 0 1 0
12 00000064 00000007 00000002 00000002 0 0 0
0f 80000000 ffffffff 80000000 00000000 0 1 0
11 80000000 ffffffff 00000000 00000000 1 0 0
10 00001234 00000000 ffffffff 00001234 0 1 0
12 00001234 00000000 00001234 00001234 0 0 0
0f fffffff9 00000000 ffffffff fffffff9 0 1 0
10 00000064 00000003 00000021 00000001 0 0 0
10 000003e8 00000007 0000008e 00000006 0 0 0
13 00000003 00000005 fffffffe 00000000 0 1 1
13 00000005 00000003 00000002 00000000 0 0 0
13 00000005 00000005 00000000 00000000 1 0 0
18 12345678 9abcdef0 00000000 00000000 1 0 0
1f ffffffff ffffffff 00000000 00000000 1 0 0
ffffffff 00000000 00000000 00000000 00000000 0 0 0

//--- dv/alu_tb.sv
// trace-driven testbench for the alu top level, run from the project root through the Makefile
`timescale 1ns/1ps
`default_nettype none
`include "alu_defs.svh"

module alu_tb
  import alu_pkg::*;
();

  localparam int MAX_LINES = 64;
  localparam int WORDS     = 8;   // op a b result remainder zero negative borrow
  localparam int TRACE_HDR = 2;   // comment lines at the top of the trace
  localparam int STALL_MAX = `ALU_DIV_CYCLES + 8;

  logic      clk;
  logic      rst;
  alu_op_e   op;
  alu_word_t a;
  alu_word_t b;
  alu_word_t result;
  alu_word_t remainder;
  logic      zero;
  logic      negative;
  logic      borrow;
  logic      stall;

  logic [31:0] trace_mem [0:MAX_LINES*WORDS-1];
  int          n_checks;
  int          word_errs;
  int          flag_errs;
  int          other_errs;

  tb_clkgen u_clk (
    .clk (clk)
  );

  alu u_dut (
    .clk       (clk),
    .rst       (rst),
    .op        (op),
    .a         (a),
    .b         (b),
    .result    (result),
    .remainder (remainder),
    .zero      (zero),
    .negative  (negative),
    .borrow    (borrow),
    .stall     (stall)
  );

  task automatic check_word(input string name, input alu_word_t exp, input alu_word_t act);
    n_checks++;
    if (act !== exp)
    begin
      word_errs++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp)
    begin
      flag_errs++;
      $display("mismatch %s expected %b actual %b", name, exp, act);
    end
  endtask

  // opcode name plus the line of the trace file
  function automatic string test_name(input alu_op_e o, input int idx);
    string op_name;
    op_name = o.name();
    if (op_name == "")
    begin
      op_name = $sformatf("INVALID_%0d", o);
    end
    return $sformatf("%s_line%0d", op_name, idx + TRACE_HDR + 1);
  endfunction

  function automatic logic is_div(input alu_op_e o);
    return (o == OP_DIV) || (o == OP_DIVU) || (o == OP_REM) || (o == OP_REMU);
  endfunction

  task automatic run_line(input int idx);
    int        base;
    int        waited;
    alu_op_e   t_op;
    string     name;
    base   = idx * WORDS;
    t_op   = alu_op_e'(trace_mem[base][`ALU_OP_W-1:0]);
    name   = test_name(t_op, idx);
    @(negedge clk);
    op = t_op;
    a  = trace_mem[base + 1];
    b  = trace_mem[base + 2];
    @(negedge clk);  // one cycle later, outputs settled
    if (is_div(t_op))
    begin
      if (!stall)
      begin
        other_errs++;
        $display("%s: stall did not rise for a divide", name);
      end
      waited = 1;
      while (stall && waited < STALL_MAX)
      begin
        @(negedge clk);
        waited++;
      end
      if (stall)
      begin
        other_errs++;
        $display("%s: stall never released", name);
        return;
      end
    end
    else
    begin
      check_flag({name, " stall"}, 1'b0, stall);
    end
    check_word({name, " result"}, trace_mem[base + 3], result);
    check_word({name, " remainder"}, trace_mem[base + 4], remainder);
    check_flag({name, " zero"}, trace_mem[base + 5][0], zero);
    check_flag({name, " negative"}, trace_mem[base + 6][0], negative);
    check_flag({name, " borrow"}, trace_mem[base + 7][0], borrow);
  endtask

  initial
  begin
    int   idx;
    int   gap;
    logic found_end;
    n_checks   = 0;
    word_errs  = 0;
    flag_errs  = 0;
    other_errs = 0;
    rst = 1'b1;
    op  = OP_AND;
    a   = '0;
    b   = '0;
    void'($urandom(76931));
    $readmemh("dv/alu_trace.txt", trace_mem);

    repeat (4) @(posedge clk);  // four rising edges under reset
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flag("reset stall", 1'b0, stall);

    idx       = 0;
    found_end = 1'b0;
    while (!found_end && idx < MAX_LINES)
    begin
      if (trace_mem[idx * WORDS] == 32'hffff_ffff)
      begin
        found_end = 1'b1;  // end marker line
      end
      else
      begin
        gap = $urandom % 4;  // idle cycles, inputs held
        repeat (gap) @(negedge clk);
        run_line(idx);
        idx++;
      end
    end
    if (!found_end)
    begin
      other_errs++;
      $display("trace end marker not found, trace file missing or too long");
    end

    $display("checks %0d, word errors %0d, flag errors %0d, other errors %0d",
             n_checks, word_errs, flag_errs, other_errs);
    if (word_errs + flag_errs + other_errs == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
// free-running testbench clock, 20 ns period, instantiated by alu_tb
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
#(
  parameter int HALF_NS = 10  // half of the 20 ns period
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #HALF_NS clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- design/alu.sv
// execute-stage alu of an RV32IMA core, top level holding the multiplier and divider
`timescale 1ns/1ps
`default_nettype none
`include "alu_defs.svh"

module alu
  import alu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  alu_op_e   op,
  input  alu_word_t a,
  input  alu_word_t b,
  output alu_word_t result,
  output alu_word_t remainder,
  output logic      zero,
  output logic      negative,
  output logic      borrow,
  output logic      stall
);

  logic      div_req;   // divide or remainder form selected
  logic      busy;
  alu_word_t product;
  alu_word_t quotient;
  alu_word_t div_rem;
  logic      lt_s;      // signed a < b
  logic      lt_u;      // unsigned a < b
  logic [4:0] shamt;

  assign div_req = (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);

  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;
  assign shamt = b[4:0];  // shift amount mod 32

  alu_multiplier u_mul (
    .op      (op),
    .a       (a),
    .b       (b),
    .product (product)
  );

  alu_divider u_div (
    .clk      (clk),
    .rst      (rst),
    .div_req  (div_req),
    .op       (op),
    .a        (a),
    .b        (b),
    .quotient (quotient),
    .div_rem  (div_rem),
    .busy     (busy)
  );

  always_comb
  begin
    result = '0;
    borrow = 1'b0;
    case (op)
      OP_AND:  result = a & b;
      OP_OR:   result = a | b;
      OP_ADD:  result = a + b;
      OP_XOR:  result = a ^ b;
      OP_SUB:  result = a - b;
      OP_NOT:  result = ~a;
      OP_SLL:  result = a << shamt;
      OP_SRL:  result = a >> shamt;
      OP_SRA:  result = $signed(a) >>> shamt;  // fills with sign bit
      OP_SLT:  result = alu_word_t'(lt_s);
      OP_SLTU: result = alu_word_t'(lt_u);
      OP_SUBU:
      begin
        {borrow, result} = {1'b0, a} - {1'b0, b};  // top bit is the borrow
      end
      OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU:
      begin
        result = product;
      end
      OP_DIV, OP_DIVU:
      begin
        result = quotient;  // valid once stall drops
      end
      OP_REM, OP_REMU:
      begin
        result = div_rem;
      end
      OP_AMOMIN:  result = lt_s ? a : b;
      OP_AMOMAX:  result = lt_s ? b : a;
      OP_AMOMINU: result = lt_u ? a : b;
      OP_AMOMAXU: result = lt_u ? b : a;
      default:    result = '0;  // unassigned codes
    endcase
  end

  assign remainder = div_req ? div_rem : '0;
  assign zero      = (result == '0);
  assign negative  = result[`ALU_XLEN-1];
  assign stall     = busy;  // core holds its inputs while high

  // a non-divide op must never see the divider stall
  a_stall_div_only: assert property (@(posedge clk) disable iff (rst)
    stall |-> div_req);

endmodule

`default_nettype wire

//--- design/alu_divider.sv
// radix-2 restoring divider for DIV/DIVU/REM/REMU, holds busy while iterating, used inside alu
`timescale 1ns/1ps
`default_nettype none
`include "alu_defs.svh"

module alu_divider
  import alu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      div_req,
  input  alu_op_e   op,
  input  alu_word_t a,
  input  alu_word_t b,
  output alu_word_t quotient,
  output alu_word_t div_rem,
  output logic      busy
);

  localparam int CNT_W = $clog2(`ALU_DIV_CYCLES + 1);

  logic               running;   // iterating
  logic               done;      // result held for current request
  logic [CNT_W-1:0]   cnt;       // iteration counter
  alu_op_e            op_q;
  alu_word_t          a_q;
  alu_word_t          b_q;
  logic               sgn_q;     // signed form captured
  alu_word_t          dvs_q;     // divisor magnitude
  alu_word_t          quo_q;     // dividend out, quotient in
  alu_word_t          rem_q;     // partial remainder

  logic               sgn_in;
  logic               same_req;
  logic               start;
  alu_word_t          a_mag;
  alu_word_t          b_mag;
  logic [`ALU_XLEN:0] trial;     // shifted remainder minus divisor
  logic               neg_quo;
  logic               neg_rem;
  logic               div_zero;
  logic               overflow;
  alu_word_t          quo_fix;
  alu_word_t          rem_fix;

  assign sgn_in = (op == OP_DIV) || (op == OP_REM);

  // any change of op or operands under a request restarts the divider
  assign same_req = (running || done) && (op == op_q) && (a == a_q) && (b == b_q);
  assign start    = div_req && !same_req;
  assign busy     = start || running;  // high in the capture cycle too

  assign a_mag = (sgn_in && a[`ALU_XLEN-1]) ? -a : a;
  assign b_mag = (sgn_in && b[`ALU_XLEN-1]) ? -b : b;

  assign trial = {rem_q, quo_q[`ALU_XLEN-1]} - {1'b0, dvs_q};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      running <= 1'b0;
      done    <= 1'b0;
      cnt     <= '0;
    end
    else if (!div_req)
    begin
      running <= 1'b0;  // request withdrawn, back to idle
      done    <= 1'b0;
      cnt     <= '0;
    end
    else if (start)
    begin
      running <= 1'b1;
      done    <= 1'b0;
      cnt     <= '0;
    end
    else if (running)
    begin
      cnt <= cnt + 1'b1;
      if (cnt == CNT_W'(`ALU_DIV_CYCLES - 1))
      begin
        running <= 1'b0;  // last quotient bit this cycle
        done    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      op_q  <= op;
      a_q   <= a;
      b_q   <= b;
      sgn_q <= sgn_in;
      dvs_q <= b_mag;
      quo_q <= a_mag;
      rem_q <= '0;
    end
    else if (running)
    begin
      quo_q <= {quo_q[`ALU_XLEN-2:0], !trial[`ALU_XLEN]};
      if (trial[`ALU_XLEN])
      begin
        rem_q <= {rem_q[`ALU_XLEN-2:0], quo_q[`ALU_XLEN-1]};  // restore
      end
      else
      begin
        rem_q <= trial[`ALU_XLEN-1:0];
      end
    end
  end

  // remainder takes the dividend's sign
  assign neg_quo  = sgn_q && (a_q[`ALU_XLEN-1] ^ b_q[`ALU_XLEN-1]);
  assign neg_rem  = sgn_q && a_q[`ALU_XLEN-1];
  assign div_zero = (b_q == '0);
  assign overflow = sgn_q && (a_q == {1'b1, {(`ALU_XLEN-1){1'b0}}}) && (b_q == '1);
  assign quo_fix  = neg_quo ? -quo_q : quo_q;
  assign rem_fix  = neg_rem ? -rem_q : rem_q;

  always_comb
  begin
    if (div_zero)
    begin
      quotient = '1;    // all ones per spec
      div_rem  = a_q;
    end
    else if (overflow)
    begin
      quotient = a_q;   // most negative / -1
      div_rem  = '0;
    end
    else
    begin
      quotient = quo_fix;
      div_rem  = rem_fix;
    end
  end

  a_cnt_range: assert property (@(posedge clk) disable iff (rst)
    cnt <= CNT_W'(`ALU_DIV_CYCLES));

  // only a fresh request may raise busy right out of reset
  a_idle_after_rst: assert property (@(posedge clk)
    $past(rst) && !div_req |-> !busy);

endmodule

`default_nettype wire

//--- design/alu_multiplier.sv
// combinational 33x33 signed multiplier for the four RISC-V M multiply forms, used inside alu
`timescale 1ns/1ps
`default_nettype none
`include "alu_defs.svh"

module alu_multiplier
  import alu_pkg::*;
(
  input  alu_op_e   op,
  input  alu_word_t a,
  input  alu_word_t b,
  output alu_word_t product
);

  logic                            a_sgn;  // a treated as signed
  logic                            b_sgn;  // b treated as signed
  logic signed [`ALU_XLEN:0]       a_ext;
  logic signed [`ALU_XLEN:0]       b_ext;
  logic signed [2*`ALU_XLEN+1:0]   prod;   // full 66-bit product
  alu_word_t                       prod_lo;
  alu_word_t                       prod_hi;

  // one extra bit per operand lets a single signed multiply
  // cover signed, unsigned and mixed operands
  assign a_sgn = (op != OP_MULHU);                   // MULHU is the only unsigned a
  assign b_sgn = (op == OP_MUL) || (op == OP_MULH);  // MULHSU and MULHU zero-extend b

  assign a_ext = {a_sgn & a[`ALU_XLEN-1], a};  // sign or zero extend
  assign b_ext = {b_sgn & b[`ALU_XLEN-1], b};

  assign prod = a_ext * b_ext;

  assign prod_lo = prod[`ALU_XLEN-1:0];
  assign prod_hi = prod[2*`ALU_XLEN-1:`ALU_XLEN];

  // low word is the same for every signedness
  always_comb
  begin
    if (op == OP_MUL)
    begin
      product = prod_lo;
    end
    else
    begin
      product = prod_hi;  // MULH, MULHSU, MULHU
    end
  end

endmodule

`default_nettype wire

//--- design/alu_pkg.sv
// opcode enum and data word type for the alu, imported by the RTL and the testbench
`default_nettype none
`include "alu_defs.svh"

package alu_pkg;

  typedef logic [`ALU_XLEN-1:0] alu_word_t;  // operand, result and remainder word

  typedef enum logic [`ALU_OP_W-1:0] {
    OP_AND     = 5'd0,
    OP_OR      = 5'd1,
    OP_ADD     = 5'd2,
    OP_XOR     = 5'd3,
    OP_SUB     = 5'd4,
    OP_NOT     = 5'd5,   // uses a only
    OP_SLL     = 5'd6,
    OP_SRL     = 5'd7,
    OP_SRA     = 5'd8,
    OP_SLT     = 5'd9,
    OP_SLTU    = 5'd10,
    OP_MUL     = 5'd11,  // low word
    OP_MULH    = 5'd12,  // high word, signed x signed
    OP_MULHSU  = 5'd13,  // high word, signed x unsigned
    OP_MULHU   = 5'd14,  // high word, unsigned x unsigned
    OP_DIV     = 5'd15,
    OP_DIVU    = 5'd16,
    OP_REM     = 5'd17,
    OP_REMU    = 5'd18,
    OP_SUBU    = 5'd19,  // subtract with borrow out
    OP_AMOMAX  = 5'd20,
    OP_AMOMINU = 5'd21,
    OP_AMOMAXU = 5'd22,
    OP_AMOMIN  = 5'd23
  } alu_op_e;

endpackage

`default_nettype wire

//--- design/alu_defs.svh
// datapath width, opcode width and divider latency macros, include in any alu source file
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// integer register width
`define ALU_XLEN 32

// opcode field width
`define ALU_OP_W 5

// divider iteration cycles, one quotient bit each
`define ALU_DIV_CYCLES 32

`endif
